/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = comp_unit_tb
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* dv/comp_unit_tb.sv */
`timescale 1ns/10ps

module comp_unit_tb import comp_pkg::*; ();

   localparam int CLK_PERIOD = 40;
   localparam int MAX_VEC    = 512;
   localparam int ENTRY_W    = 56;
   localparam logic [31:0] RAND_SEED = 32'h6a69;

   logic     clk;
   logic     rst_n;
   ll_beat_t in_beat;
   logic     in_valid;
   logic     in_ready;
   ll_beat_t out_beat;
   logic     out_valid;
   logic     out_ready;
   dcr_req_t dcr_req;
   dcr_rsp_t dcr_rsp;

   logic [ENTRY_W-1:0] vec_mem [MAX_VEC];
   int                 n_vec;
   logic               vec_loaded;
   ll_beat_t           in_q [$];
   ll_beat_t           exp_q [$];
   logic               in_fire;
   logic               stress;

   comp_unit_top UUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_beat_i   (in_beat),
      .in_valid_i  (in_valid),
      .in_ready_o  (in_ready),
      .out_beat_o  (out_beat),
      .out_valid_o (out_valid),
      .out_ready_i (out_ready),
      .dcr_req_i   (dcr_req),
      .dcr_rsp_o   (dcr_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   task automatic report_failure();
      $display("Some tests failed");
      $fatal(1, "run stopped at the first failing check");
   endtask

   task automatic check_beat(input string name, input ll_beat_t exp, input ll_beat_t act);
      if (act !== exp) begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         report_failure();
      end
   endtask

   task automatic check_dcr(input string name, input dcr_rsp_t exp, input dcr_rsp_t act);
      if (act !== exp) begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         report_failure();
      end
   endtask

   task automatic compare_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         report_failure();
      end
   endtask

   // entry layout tag rem flags addr data
   function automatic ll_beat_t entry_to_beat(input logic [ENTRY_W-1:0] ent);
      ll_beat_t b;
      b.data = ent[31:0];
      b.rem  = ent[51:48];
      b.sof  = ent[47];
      b.eof  = ent[46];
      b.sop  = ent[45];
      b.eop  = ent[44];
      return b;
   endfunction

   task automatic drain_streams();
      while (in_q.size() != 0 || exp_q.size() != 0) begin
         @(negedge clk);
      end
   endtask

   task automatic reg_access(input logic is_write, input logic [DCR_ADDR_W-1:0] addr,
                             input logic [WORD_W-1:0] data);
      dcr_rsp_t exp_rsp;
      @(posedge clk);
      #2;
      dcr_req = '{addr: addr, wdata: data, read: !is_write, write: is_write};
      @(negedge clk);
      compare_bit("dcr_rsp_o.ack", 1'b0, dcr_rsp.ack);
      @(posedge clk);
      #2;
      dcr_req = '0;
      @(negedge clk);
      if (is_write) begin
         compare_bit("dcr_rsp_o.ack", 1'b1, dcr_rsp.ack);
      end else begin
         exp_rsp = '{ack: 1'b1, rdata: data};
         check_dcr("dcr_rsp_o", exp_rsp, dcr_rsp);
      end
      @(negedge clk);
      compare_bit("dcr_rsp_o.ack", 1'b0, dcr_rsp.ack);
      // soft reset hits the stages one edge after the ack
      if (is_write && addr == REG_CTRL && data[WORD_W-1]) begin
         compare_bit("out_valid_o", 1'b0, out_valid);
         compare_bit("in_ready_o", 1'b0, in_ready);
      end
   endtask

   // handshakes are decided here half a cycle before the edge
   always @(negedge clk) begin : sample_ports
      ll_beat_t exp_beat;
      in_fire = in_valid && in_ready;
      if (rst_n && out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            $display("output word %h arrived with no expected word left", out_beat);
            report_failure();
         end else begin
            exp_beat = exp_q.pop_front();
            check_beat("out_beat_o", exp_beat, out_beat);
         end
      end
   end

   initial begin : drive_stimulus
      forever begin
         @(posedge clk);
         #2;
         if (in_fire) begin
            void'(in_q.pop_front());
         end
         if (in_q.size() != 0) begin
            in_beat  = in_q[0];
            in_valid = 1'b1;
         end else begin
            in_beat  = '0;
            in_valid = 1'b0;
         end
         // stall on about a third of cycles
         out_ready = stress ? (($urandom % 3) != 0) : 1'b1;
      end
   end

   initial begin : watchdog
      wait (vec_loaded === 1'b1);
      #(n_vec * 40 * CLK_PERIOD);
      $display("timed out after %0d cycles before all vectors were done", n_vec * 40);
      report_failure();
   end

   initial begin : run_vectors
      logic [ENTRY_W-1:0] ent;
      int                 idx;
      rst_n      = 1'b0;
      in_beat    = '0;
      in_valid   = 1'b0;
      out_ready  = 1'b1;
      dcr_req    = '0;
      in_fire    = 1'b0;
      stress     = 1'b0;
      n_vec      = 0;
      vec_loaded = 1'b0;
      void'($urandom(RAND_SEED));
      for (idx = 0; idx < MAX_VEC; idx++) begin
         vec_mem[idx] = '0;
      end
      $readmemh("dv/comp_vectors.txt", vec_mem);
      while (n_vec < MAX_VEC && vec_mem[n_vec][55:52] != 4'h0) begin
         n_vec++;
      end
      vec_loaded = 1'b1;
      if (n_vec == 0) begin
         $display("no vectors could be read from dv/comp_vectors.txt");
         report_failure();
      end else begin
         repeat (3) @(posedge clk);
         #2;
         rst_n = 1'b1;
         for (idx = 0; idx < n_vec; idx++) begin
            ent = vec_mem[idx];
            case (ent[55:52])
               4'h1: in_q.push_back(entry_to_beat(ent));
               4'h2: exp_q.push_back(entry_to_beat(ent));
               4'h3: begin
                  drain_streams();
                  reg_access(1'b0, ent[41:32], ent[31:0]);
               end
               4'h4: begin
                  drain_streams();
                  reg_access(1'b1, ent[41:32], ent[31:0]);
               end
               4'h6: begin
                  drain_streams();
                  stress = ent[0];
               end
               default: begin
                  $display("vector %0d has unknown tag %h", idx, ent[55:52]);
                  report_failure();
               end
            endcase
         end
         drain_streams();
         repeat (2) @(posedge clk);
         $display("All tests passed");
         $finish;
      end
   end

endmodule

/* dv/comp_vectors.txt */
// entry digits are tag rem flags addr(3) data(8)
// flag bits from high to low are sof eof sop eop
// tags 1 input 2 expected output 3 read 4 write 6 output stall on or off
60000000000001
10800011110000 10000011110001 10000011110002 10000011110003 100000A0001234 10000000000012
1000000000045A 10000011110007 10200001020304 10000005060708 100000090A0B0C 1000000D0E0F10
13500011121314
20A00001020304 20000005060708 200000090A0B0C 2000000D0E0F10 23100011120000 20000000000000
20000000000000 20000000000000 20000000000000 200000B0000000 20000000000012 2000000000005A
20400000000000
10800022220000 10000022220001 10000022220002 10000022220003 10000060000000 10000000000020
100000000003FF 10000022220007 102000AAAA0001 100000AAAA0002 101000AAAA0003 100000DEAD0000
104000DEAD0001
20A000AAAA0001 200000AAAA0002 201000AAAA0003 20000000000000 20000000000000 20000000000000
20000000000000 20000060000000 20000000000020 200000000003FF 20400000000000
10800033330000 10000033330001 10000033330002 10000033330003 100000C0000000 10000000000015
10000000000123 10000033330007 102000C0C00001 100000C0C00002 100000C0C00003 100000C0C00004
100000C0C00005 175000C0C000FF
20A000C0C00001 200000C0C00002 200000C0C00003 200000C0C00004 200000C0C00005 271000C0000000
20000000000000 20000000000000 20000000000000 20000000000000 200000D0000000 20000000000015
20000000000123 20400000000000
60000000000000 30000E10081100 30000FAA5555AA 30000100000003 300002C0000123 30000000000000
40000080000000 30000100000003
10800044440000 10000044440001 10000044440002 10000044440003 10000020000000 10000000000007
100000000002A5 10000044440007 102000D0D0D0D1 115000D0D0D0D2
20A000D0D0D0D1 211000D0D0D000 20000000000000 20000000000000 20000000000000 20000000000000
20000030000000 20000000000007 200000000002A5 20400000000000
30000100000004 300002200002A5

/* source/beat_fifo.sv */
`timescale 1ns/10ps

module beat_fifo import comp_pkg::*; #(
   parameter type payload_t = logic [WORD_W-1:0]
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     soft_rst_i,
   input  payload_t wr_data_i,
   input  logic     wr_valid_i,
   output logic     wr_ready_o,
   output payload_t rd_data_o,
   output logic     rd_valid_o,
   input  logic     rd_ready_i
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   payload_t         mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             push;
   logic             pop;

   assign wr_ready_o = (count != (PTR_W+1)'(FIFO_DEPTH));
   assign rd_valid_o = (count != '0);
   assign rd_data_o  = mem[rd_ptr];

   assign push = wr_valid_i && wr_ready_o;
   assign pop  = rd_valid_o && rd_ready_i;

   // pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clk) begin
      if (!rst_n || soft_rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

endmodule

/* source/comp_pkg.sv */
package comp_pkg;

   localparam int WORD_W       = 32;
   localparam int REM_W        = 4;
   localparam int HDR_WORDS    = 8;
   localparam int HDR_CNT_W    = $clog2(HDR_WORDS);
   localparam int HDR_FLAG_IDX = 4;
   localparam int HDR_LEN_IDX  = 5;
   localparam int HDR_TASK_IDX = 6;
   localparam int TASK_W       = 10;
   localparam int FLAG_W       = 3;
   localparam int LEN_W        = 32;
   localparam int BYTES_W      = 4;
   localparam int DCR_ADDR_W   = 10;
   localparam int FIFO_DEPTH   = 4;

   localparam logic [DCR_ADDR_W-1:0] REG_CTRL   = 10'd0;
   localparam logic [DCR_ADDR_W-1:0] REG_FRAMES = 10'd1;
   localparam logic [DCR_ADDR_W-1:0] REG_TASK   = 10'd2;
   localparam logic [DCR_ADDR_W-1:0] REG_ID     = 10'd14;
   localparam logic [DCR_ADDR_W-1:0] REG_SIG    = 10'd15;

   localparam logic [WORD_W-1:0] ID_WORD  = 32'h1008_1100;
   localparam logic [WORD_W-1:0] SIG_WORD = 32'haa55_55aa;

   typedef struct packed {
      logic [WORD_W-1:0] data;
      logic [REM_W-1:0]  rem;
      logic              sof;
      logic              eof;
      logic              sop;
      logic              eop;
   } ll_beat_t;

   typedef struct packed {
      logic [FLAG_W-1:0] flag;
      logic [LEN_W-1:0]  src_len;
      logic [TASK_W-1:0] task_idx;
   } desc_t;

   // bytes counted from the high end of data
   typedef struct packed {
      logic [2*WORD_W-1:0] data;
      logic [BYTES_W-1:0]  bytes;
      logic                last;
   } pair_beat_t;

   typedef struct packed {
      logic [DCR_ADDR_W-1:0] addr;
      logic [WORD_W-1:0]     wdata;
      logic                  read;
      logic                  write;
   } dcr_req_t;

   typedef struct packed {
      logic              ack;
      logic [WORD_W-1:0] rdata;
   } dcr_rsp_t;

   // rem code of a last word to its valid byte count
   function automatic logic [BYTES_W-1:0] rem_to_bytes(input logic [REM_W-1:0] rem);
      case (rem)
         4'b0001: return BYTES_W'(3);
         4'b0011: return BYTES_W'(2);
         4'b0111: return BYTES_W'(1);
         default: return BYTES_W'(4);
      endcase
   endfunction

   function automatic logic [REM_W-1:0] bytes_to_rem(input logic [BYTES_W-1:0] n);
      case (n)
         BYTES_W'(3): return 4'b0001;
         BYTES_W'(2): return 4'b0011;
         BYTES_W'(1): return 4'b0111;
         default:     return 4'b0000;
      endcase
   endfunction

endpackage

/* source/comp_unit_top.sv */
`timescale 1ns/10ps

module comp_unit_top import comp_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  ll_beat_t in_beat_i,
   input  logic     in_valid_i,
   output logic     in_ready_o,
   output ll_beat_t out_beat_o,
   output logic     out_valid_o,
   input  logic     out_ready_i,
   input  dcr_req_t dcr_req_i,
   output dcr_rsp_t dcr_rsp_o
);

   logic       soft_rst;
   desc_t      ing_desc;
   logic       ing_desc_valid;
   logic       ing_desc_ready;
   desc_t      egr_desc;
   logic       egr_desc_valid;
   logic       egr_desc_ready;
   pair_beat_t ing_pair;
   logic       ing_pair_valid;
   logic       ing_pair_ready;
   pair_beat_t egr_pair;
   logic       egr_pair_valid;
   logic       egr_pair_ready;
   logic       frame_done;
   desc_t      done_desc;

   frame_ingress u_ingress (
      .clk          (clk),
      .rst_n        (rst_n),
      .soft_rst_i   (soft_rst),
      .in_beat_i    (in_beat_i),
      .in_valid_i   (in_valid_i),
      .in_ready_o   (in_ready_o),
      .desc_o       (ing_desc),
      .desc_valid_o (ing_desc_valid),
      .desc_ready_i (ing_desc_ready),
      .pair_o       (ing_pair),
      .pair_valid_o (ing_pair_valid),
      .pair_ready_i (ing_pair_ready)
   );

   // next header can be parsed while the previous frame drains
   beat_fifo #(.payload_t(desc_t)) u_desc_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .soft_rst_i (soft_rst),
      .wr_data_i  (ing_desc),
      .wr_valid_i (ing_desc_valid),
      .wr_ready_o (ing_desc_ready),
      .rd_data_o  (egr_desc),
      .rd_valid_o (egr_desc_valid),
      .rd_ready_i (egr_desc_ready)
   );

   beat_fifo #(.payload_t(pair_beat_t)) u_pair_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .soft_rst_i (soft_rst),
      .wr_data_i  (ing_pair),
      .wr_valid_i (ing_pair_valid),
      .wr_ready_o (ing_pair_ready),
      .rd_data_o  (egr_pair),
      .rd_valid_o (egr_pair_valid),
      .rd_ready_i (egr_pair_ready)
   );

   frame_egress u_egress (
      .clk          (clk),
      .rst_n        (rst_n),
      .soft_rst_i   (soft_rst),
      .desc_i       (egr_desc),
      .desc_valid_i (egr_desc_valid),
      .desc_ready_o (egr_desc_ready),
      .pair_i       (egr_pair),
      .pair_valid_i (egr_pair_valid),
      .pair_ready_o (egr_pair_ready),
      .out_beat_o   (out_beat_o),
      .out_valid_o  (out_valid_o),
      .out_ready_i  (out_ready_i),
      .frame_done_o (frame_done),
      .done_desc_o  (done_desc)
   );

   // busy while a word waits at the output
   dcr_status u_dcr (
      .clk          (clk),
      .rst_n        (rst_n),
      .dcr_req_i    (dcr_req_i),
      .dcr_rsp_o    (dcr_rsp_o),
      .frame_done_i (frame_done),
      .done_desc_i  (done_desc),
      .busy_i       (out_valid_o),
      .soft_rst_o   (soft_rst)
   );

endmodule

/* source/dcr_status.sv */
`timescale 1ns/10ps

module dcr_status import comp_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  dcr_req_t dcr_req_i,
   output dcr_rsp_t dcr_rsp_o,
   input  logic     frame_done_i,
   input  desc_t    done_desc_i,
   input  logic     busy_i,
   output logic     soft_rst_o
);

   logic              ack_q;
   logic [WORD_W-1:0] rdata_q;
   logic [WORD_W-1:0] rd_mux;
   logic [WORD_W-1:0] frame_cnt;
   logic [TASK_W-1:0] last_task;
   logic [FLAG_W-1:0] last_flag;
   logic              soft_rst_q;
   logic              ctrl_wr;

   always_comb begin
      rd_mux = '0;
      case (dcr_req_i.addr)
         REG_CTRL:   rd_mux[0] = busy_i;
         REG_FRAMES: rd_mux = frame_cnt;
         REG_TASK: begin
            rd_mux[WORD_W-1 -: FLAG_W] = last_flag;
            rd_mux[TASK_W-1:0]         = last_task;
         end
         REG_ID:     rd_mux = ID_WORD;
         REG_SIG:    rd_mux = SIG_WORD;
         default:    rd_mux = '0;
      endcase
   end

   // reset request lives in the top bit of the control word
   assign ctrl_wr = dcr_req_i.write && (dcr_req_i.addr == REG_CTRL) &&
                    dcr_req_i.wdata[WORD_W-1];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack_q      <= 1'b0;
         soft_rst_q <= 1'b0;
         frame_cnt  <= '0;
         last_task  <= '0;
         last_flag  <= '0;
      end else begin
         ack_q      <= dcr_req_i.read || dcr_req_i.write;
         soft_rst_q <= ctrl_wr;
         if (frame_done_i) begin
            frame_cnt <= frame_cnt + 1'b1;
            last_task <= done_desc_i.task_idx;
            last_flag <= done_desc_i.flag;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (dcr_req_i.read) begin
         rdata_q <= rd_mux;
      end
   end

   assign dcr_rsp_o  = '{ack: ack_q, rdata: rdata_q};
   assign soft_rst_o = soft_rst_q;

endmodule

/* source/frame_egress.sv */
`timescale 1ns/10ps

module frame_egress import comp_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       soft_rst_i,
   input  desc_t      desc_i,
   input  logic       desc_valid_i,
   output logic       desc_ready_o,
   input  pair_beat_t pair_i,
   input  logic       pair_valid_i,
   output logic       pair_ready_o,
   output ll_beat_t   out_beat_o,
   output logic       out_valid_o,
   input  logic       out_ready_i,
   output logic       frame_done_o,
   output desc_t      done_desc_o
);

   typedef enum logic [1:0] {
      ST_HI,
      ST_LO,
      ST_TRL,
      ST_WAIT
   } state_t;

   state_t               state;
   logic                 first_q;
   logic [HDR_CNT_W-1:0] trl_cnt;
   logic [LEN_W-1:0]     byte_sum;
   ll_beat_t             out_q;
   logic                 out_valid_q;
   ll_beat_t             nxt;
   logic                 can_load;
   logic                 load;
   logic [BYTES_W-1:0]   hi_bytes;
   logic [BYTES_W-1:0]   lo_bytes;
   logic [BYTES_W-1:0]   word_bytes;
   logic                 hi_only;
   logic                 status;

   assign hi_bytes = (pair_i.bytes > BYTES_W'(4)) ? BYTES_W'(4) : pair_i.bytes;
   assign lo_bytes = pair_i.bytes - BYTES_W'(4);
   assign hi_only  = pair_i.last && (pair_i.bytes <= BYTES_W'(4));
   assign status   = (byte_sum == desc_i.src_len);
   assign can_load = !out_valid_q || out_ready_i;

   always_comb begin
      nxt        = '0;
      load       = 1'b0;
      word_bytes = '0;
      case (state)
         ST_HI: begin
            load       = can_load && desc_valid_i && pair_valid_i;
            word_bytes = hi_bytes;
            nxt.data   = pair_i.data[2*WORD_W-1:WORD_W];
            nxt.rem    = bytes_to_rem(hi_bytes);
            nxt.sof    = first_q;
            nxt.sop    = first_q;
            nxt.eop    = hi_only;
         end
         ST_LO: begin
            load       = can_load && pair_valid_i;
            word_bytes = lo_bytes;
            nxt.data   = pair_i.data[WORD_W-1:0];
            nxt.rem    = bytes_to_rem(lo_bytes);
            nxt.eop    = pair_i.last;
         end
         ST_TRL: begin
            load = can_load;
            // only trailer words 4 to 6 carry data
            if (trl_cnt == HDR_CNT_W'(HDR_FLAG_IDX)) begin
               nxt.data = {desc_i.flag, status, {(WORD_W-FLAG_W-1){1'b0}}};
            end else if (trl_cnt == HDR_CNT_W'(HDR_LEN_IDX)) begin
               nxt.data = desc_i.src_len;
            end else if (trl_cnt == HDR_CNT_W'(HDR_TASK_IDX)) begin
               nxt.data = {{(WORD_W-TASK_W){1'b0}}, desc_i.task_idx};
            end
            nxt.eof = (trl_cnt == HDR_CNT_W'(HDR_WORDS-1));
         end
         default: begin
            load = 1'b0;
         end
      endcase
   end

   // beat leaves the queue with its last word
   assign pair_ready_o = load && ((state == ST_HI && hi_only) || state == ST_LO);

   assign frame_done_o = out_valid_q && out_ready_i && out_q.eof;
   assign desc_ready_o = frame_done_o;
   assign done_desc_o  = desc_i;
   assign out_beat_o   = out_q;
   assign out_valid_o  = out_valid_q;

   always_ff @(posedge clk) begin
      if (!rst_n || soft_rst_i) begin
         state       <= ST_HI;
         first_q     <= 1'b1;
         trl_cnt     <= '0;
         byte_sum    <= '0;
         out_valid_q <= 1'b0;
      end else begin
         if (out_valid_q && out_ready_i) begin
            out_valid_q <= 1'b0;
         end
         if (load) begin
            out_valid_q <= 1'b1;
            byte_sum    <= byte_sum + LEN_W'(word_bytes);
         end
         case (state)
            ST_HI: begin
               if (load) begin
                  first_q <= 1'b0;
                  state   <= hi_only ? ST_TRL : ST_LO;
               end
            end
            ST_LO: begin
               if (load) begin
                  state <= pair_i.last ? ST_TRL : ST_HI;
               end
            end
            ST_TRL: begin
               if (load) begin
                  trl_cnt <= trl_cnt + 1'b1;
                  if (trl_cnt == HDR_CNT_W'(HDR_WORDS-1)) begin
                     state <= ST_WAIT;
                  end
               end
            end
            default: begin
               // eof still in the output register
               if (frame_done_o) begin
                  state    <= ST_HI;
                  first_q  <= 1'b1;
                  byte_sum <= '0;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         out_q <= nxt;
      end
   end

endmodule

/* source/frame_ingress.sv */
`timescale 1ns/10ps

module frame_ingress import comp_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       soft_rst_i,
   input  ll_beat_t   in_beat_i,
   input  logic       in_valid_i,
   output logic       in_ready_o,
   output desc_t      desc_o,
   output logic       desc_valid_o,
   input  logic       desc_ready_i,
   output pair_beat_t pair_o,
   output logic       pair_valid_o,
   input  logic       pair_ready_i
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_HDR,
      ST_HI,
      ST_LO,
      ST_DRAIN
   } state_t;

   state_t               state;
   logic [HDR_CNT_W-1:0] hdr_cnt;
   logic                 rdy_q;
   logic [FLAG_W-1:0]    flag_q;
   logic [LEN_W-1:0]     len_q;
   logic [TASK_W-1:0]    task_q;
   logic [WORD_W-1:0]    hi_q;
   logic                 accept;
   logic                 hdr_last;
   logic                 payload_st;
   logic [WORD_W-1:0]    word_masked;
   logic [BYTES_W-1:0]   word_bytes;

   function automatic logic [WORD_W-1:0] mask_word(input logic [WORD_W-1:0] d,
                                                   input logic [REM_W-1:0]  rem);
      case (rem)
         4'b0001: return {d[31:8], 8'h0};
         4'b0011: return {d[31:16], 16'h0};
         4'b0111: return {d[31:24], 24'h0};
         default: return d;
      endcase
   endfunction

   assign hdr_last   = (state == ST_HDR) && (hdr_cnt == HDR_CNT_W'(HDR_WORDS-1));
   assign payload_st = (state == ST_HI) || (state == ST_LO);

   // hold off while the queue we would push into is full
   assign in_ready_o = rdy_q && !(hdr_last && !desc_ready_i) &&
                       !(payload_st && !pair_ready_i);
   assign accept     = in_valid_i && in_ready_o;

   assign word_masked = in_beat_i.eop ? mask_word(in_beat_i.data, in_beat_i.rem)
                                      : in_beat_i.data;
   assign word_bytes  = in_beat_i.eop ? rem_to_bytes(in_beat_i.rem) : BYTES_W'(4);

   assign desc_o       = '{flag: flag_q, src_len: len_q, task_idx: task_q};
   assign desc_valid_o = accept && hdr_last;

   always_comb begin
      if (state == ST_LO) begin
         pair_o.data  = {hi_q, word_masked};
         pair_o.bytes = BYTES_W'(4) + word_bytes;
      end else begin
         pair_o.data  = {word_masked, {WORD_W{1'b0}}};
         pair_o.bytes = word_bytes;
      end
      pair_o.last = in_beat_i.eop;
   end

   // eop in the high half closes the pair early
   assign pair_valid_o = accept && ((state == ST_LO) || (state == ST_HI && in_beat_i.eop));

   always_ff @(posedge clk) begin
      if (!rst_n || soft_rst_i) begin
         state   <= ST_IDLE;
         hdr_cnt <= '0;
         rdy_q   <= 1'b0;
      end else begin
         rdy_q <= 1'b1;
         if (accept) begin
            case (state)
               ST_IDLE: begin
                  if (in_beat_i.sof) begin
                     state   <= ST_HDR;
                     hdr_cnt <= HDR_CNT_W'(1);
                  end
               end
               ST_HDR: begin
                  hdr_cnt <= hdr_cnt + 1'b1;
                  if (hdr_last) begin
                     state <= ST_HI;
                  end
               end
               ST_HI, ST_LO: begin
                  if (in_beat_i.eop) begin
                     state <= in_beat_i.eof ? ST_IDLE : ST_DRAIN;
                  end else begin
                     state <= (state == ST_HI) ? ST_LO : ST_HI;
                  end
               end
               default: begin
                  // trailing words are dropped up to eof
                  if (in_beat_i.eof) begin
                     state <= ST_IDLE;
                  end
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept && state == ST_HDR) begin
         if (hdr_cnt == HDR_CNT_W'(HDR_FLAG_IDX)) begin
            flag_q <= in_beat_i.data[WORD_W-1 -: FLAG_W];
         end
         if (hdr_cnt == HDR_CNT_W'(HDR_LEN_IDX)) begin
            len_q <= in_beat_i.data;
         end
         if (hdr_cnt == HDR_CNT_W'(HDR_TASK_IDX)) begin
            task_q <= in_beat_i.data[TASK_W-1:0];
         end
      end
      if (accept && state == ST_HI) begin
         hi_q <= word_masked;
      end
   end

endmodule

/* src.f */
source/comp_pkg.sv
source/beat_fifo.sv
source/frame_ingress.sv
source/frame_egress.sv
source/dcr_status.sv
source/comp_unit_top.sv
dv/comp_unit_tb.sv
